// File: logic/la32_isa_pkg.sv
`default_nettype none

package la32_isa_pkg;

    ////////////////////////////////////////////////////////////
    // architectural sizes
    ////////////////////////////////////////////////////////////

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 32;

    localparam logic [xlen-1:0]       reset_pc = 32'h1c00_0000;

    // bl always links through r1
    localparam logic [reg_addr_w-1:0] link_reg = 5'd1;

    ////////////////////////////////////////////////////////////
    // instruction and alu encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        op_add_w,
        op_sub_w,
        op_slt,
        op_sltu,
        op_nor,
        op_and,
        op_or,
        op_xor,
        op_slli_w,
        op_srli_w,
        op_srai_w,
        op_addi_w,
        op_lu12i_w,
        op_ld_w,
        op_st_w,
        op_jirl,
        op_b,
        op_bl,
        op_beq,
        op_bne,
        op_invalid
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_t;

endpackage

`default_nettype wire

// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

    import la32_isa_pkg::*;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback
    } core_state_t;

    // everything execute, memory and writeback need from one instruction
    typedef struct packed {
        opcode_t                op;
        alu_op_t                alu_op;
        logic                   src1_is_pc;
        logic                   src2_is_imm;
        logic                   is_load;
        logic                   is_store;
        logic                   is_branch;
        logic                   is_jump;
        logic                   reg_write;
        logic [reg_addr_w-1:0]  dest;
        logic [xlen-1:0]        imm;
        logic [xlen-1:0]        br_offs;
        logic                   src2_is_rd;
    } decode_ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] alu_result;
        logic            taken;
        logic [xlen-1:0] target;
    } exec_result_t;

endpackage

`default_nettype wire

// File: logic/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode import la32_isa_pkg::*, core_pkg::*; (
    input  logic [xlen-1:0]       inst,
    output decode_ctrl_t          ctrl,
    output logic [reg_addr_w-1:0] rj,
    output logic [reg_addr_w-1:0] rkd
);

    opcode_t               op;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rk;
    logic [xlen-1:0]       ui5;
    logic [xlen-1:0]       si12;
    logic [xlen-1:0]       si20;
    logic [xlen-1:0]       si16;
    logic [xlen-1:0]       si26;

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    assign ui5  = {27'b0, inst[14:10]};
    assign si12 = {{20{inst[21]}}, inst[21:10]};
    assign si20 = {inst[24:5], 12'b0};
    assign si16 = {{14{inst[25]}}, inst[25:10], 2'b0};
    assign si26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};

    ////////////////////////////////////////////////////////////
    // opcode match
    ////////////////////////////////////////////////////////////

    always_comb begin
        op = op_invalid;
        case (inst[31:26])
            6'h00: begin
                if (inst[25:22] == 4'h0 && inst[21:20] == 2'h1) begin
                    case (inst[19:15])
                        5'h00:   op = op_add_w;
                        5'h02:   op = op_sub_w;
                        5'h04:   op = op_slt;
                        5'h05:   op = op_sltu;
                        5'h08:   op = op_nor;
                        5'h09:   op = op_and;
                        5'h0a:   op = op_or;
                        5'h0b:   op = op_xor;
                        default: op = op_invalid;
                    endcase
                end else if (inst[25:22] == 4'h1 && inst[21:20] == 2'h0) begin
                    case (inst[19:15])
                        5'h01:   op = op_slli_w;
                        5'h09:   op = op_srli_w;
                        5'h11:   op = op_srai_w;
                        default: op = op_invalid;
                    endcase
                end else if (inst[25:22] == 4'ha) begin
                    op = op_addi_w;
                end
            end
            6'h05: if (!inst[25]) op = op_lu12i_w;
            6'h0a: begin
                if (inst[25:22] == 4'h2) begin
                    op = op_ld_w;
                end else if (inst[25:22] == 4'h6) begin
                    op = op_st_w;
                end
            end
            6'h13:   op = op_jirl;
            6'h14:   op = op_b;
            6'h15:   op = op_bl;
            6'h16:   op = op_beq;
            6'h17:   op = op_bne;
            default: op = op_invalid;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // control fields
    ////////////////////////////////////////////////////////////

    always_comb begin
        ctrl         = '0;
        ctrl.op      = op;
        ctrl.alu_op  = alu_add;
        ctrl.dest    = rd;
        ctrl.imm     = si12;
        ctrl.br_offs = si16;
        case (op)
            op_add_w:   ctrl.reg_write = 1'b1;
            op_sub_w:   begin ctrl.alu_op = alu_sub;  ctrl.reg_write = 1'b1; end
            op_slt:     begin ctrl.alu_op = alu_slt;  ctrl.reg_write = 1'b1; end
            op_sltu:    begin ctrl.alu_op = alu_sltu; ctrl.reg_write = 1'b1; end
            op_nor:     begin ctrl.alu_op = alu_nor;  ctrl.reg_write = 1'b1; end
            op_and:     begin ctrl.alu_op = alu_and;  ctrl.reg_write = 1'b1; end
            op_or:      begin ctrl.alu_op = alu_or;   ctrl.reg_write = 1'b1; end
            op_xor:     begin ctrl.alu_op = alu_xor;  ctrl.reg_write = 1'b1; end
            op_slli_w, op_srli_w, op_srai_w: begin
                ctrl.alu_op      = (op == op_slli_w) ? alu_sll :
                                   (op == op_srli_w) ? alu_srl : alu_sra;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = ui5;
                ctrl.reg_write   = 1'b1;
            end
            op_addi_w: begin
                ctrl.src2_is_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            op_lu12i_w: begin
                ctrl.alu_op      = alu_lui;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = si20;
                ctrl.reg_write   = 1'b1;
            end
            op_ld_w: begin
                ctrl.src2_is_imm = 1'b1;
                ctrl.is_load     = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            op_st_w: begin
                ctrl.src2_is_imm = 1'b1;
                ctrl.is_store    = 1'b1;
                ctrl.src2_is_rd  = 1'b1;
            end
            op_jirl, op_bl: begin
                // the alu forms the link value pc + 4
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = 32'd4;
                ctrl.is_jump     = 1'b1;
                ctrl.reg_write   = 1'b1;
                if (op == op_bl) begin
                    ctrl.dest    = link_reg;
                    ctrl.br_offs = si26;
                end
            end
            op_b: begin
                ctrl.is_branch = 1'b1;
                ctrl.br_offs   = si26;
            end
            op_beq, op_bne: begin
                ctrl.is_branch  = 1'b1;
                ctrl.src2_is_rd = 1'b1;
            end
            default: ctrl.reg_write = 1'b0;
        endcase
    end

    assign rkd = ctrl.src2_is_rd ? rd : rk;

endmodule

`default_nettype wire

// File: logic/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import la32_isa_pkg::*; (
    input  logic                  clk,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]       wdata
);

    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 may be written but always reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: logic/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit import la32_isa_pkg::*, core_pkg::*; (
    input  decode_ctrl_t    ctrl,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rj_value,
    input  logic [xlen-1:0] rkd_value,
    output exec_result_t    result
);

    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [4:0]      shamt;
    logic            cond;

    assign src1  = ctrl.src1_is_pc ? pc : rj_value;
    assign src2  = ctrl.src2_is_imm ? ctrl.imm : rkd_value;
    assign shamt = src2[4:0];

    ////////////////////////////////////////////////////////////
    // alu
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (ctrl.alu_op)
            alu_add:  result.alu_result = src1 + src2;
            alu_sub:  result.alu_result = src1 - src2;
            alu_slt:  result.alu_result = {31'b0, $signed(src1) < $signed(src2)};
            alu_sltu: result.alu_result = {31'b0, src1 < src2};
            alu_and:  result.alu_result = src1 & src2;
            alu_nor:  result.alu_result = ~(src1 | src2);
            alu_or:   result.alu_result = src1 | src2;
            alu_xor:  result.alu_result = src1 ^ src2;
            alu_sll:  result.alu_result = src1 << shamt;
            alu_srl:  result.alu_result = src1 >> shamt;
            alu_sra:  result.alu_result = $unsigned($signed(src1) >>> shamt);
            alu_lui:  result.alu_result = src2;
            default:  result.alu_result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // branch decision and target
    ////////////////////////////////////////////////////////////

    // b is unconditional, beq and bne compare rj with rd
    always_comb begin
        case (ctrl.op)
            op_beq:  cond = (rj_value == rkd_value);
            op_bne:  cond = (rj_value != rkd_value);
            op_b:    cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    assign result.taken  = ctrl.is_jump || (ctrl.is_branch && cond);

    // jirl is the only register-relative target
    assign result.target = (ctrl.op == op_jirl) ? rj_value + ctrl.br_offs
                                                : pc + ctrl.br_offs;

endmodule

`default_nettype wire

// File: logic/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage import la32_isa_pkg::*, core_pkg::*; (
    input  decode_ctrl_t          ctrl,
    input  exec_result_t          result,
    input  logic [xlen-1:0]       load_data,
    input  logic                  writeback,
    output logic                  rf_we,
    output logic [reg_addr_w-1:0] rf_waddr,
    output logic [xlen-1:0]       rf_wdata
);

    // load data arrives straight from the data sram in the writeback cycle
    assign rf_wdata = ctrl.is_load ? load_data : result.alu_result;

    assign rf_waddr = ctrl.dest;

    assign rf_we    = writeback && ctrl.reg_write;

endmodule

`default_nettype wire

// File: logic/multicycle_core.sv
`timescale 1ns/1ps
`default_nettype none

module multicycle_core import la32_isa_pkg::*, core_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    // instruction sram
    output logic [xlen-1:0]       inst_sram_addr,
    input  logic [xlen-1:0]       inst_sram_rdata,
    // data sram
    output logic                  data_sram_we,
    output logic [xlen-1:0]       data_sram_addr,
    output logic [xlen-1:0]       data_sram_wdata,
    input  logic [xlen-1:0]       data_sram_rdata,
    // writeback trace
    output logic [xlen-1:0]       debug_wb_pc,
    output logic [3:0]            debug_wb_rf_we,
    output logic [reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [xlen-1:0]       debug_wb_rf_wdata
);

    core_state_t           state;
    core_state_t           state_next;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       pc_seq;
    logic [xlen-1:0]       pc_next;

    decode_ctrl_t          dec_ctrl;
    logic [reg_addr_w-1:0] dec_rj;
    logic [reg_addr_w-1:0] dec_rkd;
    logic [xlen-1:0]       rf_rdata1;
    logic [xlen-1:0]       rf_rdata2;

    decode_ctrl_t          ctrl_q;
    logic [xlen-1:0]       rj_q;
    logic [xlen-1:0]       rkd_q;
    exec_result_t          exec_res;
    exec_result_t          res_q;

    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;

    ////////////////////////////////////////////////////////////
    // state machine and pc
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            st_fetch:     state_next = st_decode;
            st_decode:    state_next = (dec_ctrl.op == op_invalid) ? st_fetch : st_execute;
            st_execute: begin
                if (ctrl_q.is_branch) begin
                    state_next = st_fetch;
                end else if (ctrl_q.is_load || ctrl_q.is_store) begin
                    state_next = st_memory;
                end else begin
                    state_next = st_writeback;
                end
            end
            st_memory:    state_next = ctrl_q.is_load ? st_writeback : st_fetch;
            st_writeback: state_next = st_fetch;
            default:      state_next = st_fetch;
        endcase
    end

    // the pc moves only in the last state of each instruction
    assign pc_seq = pc + 32'd4;

    always_comb begin
        pc_next = pc;
        case (state)
            st_decode: begin
                if (dec_ctrl.op == op_invalid) pc_next = pc_seq;
            end
            st_execute: begin
                if (ctrl_q.is_branch) pc_next = exec_res.taken ? exec_res.target : pc_seq;
            end
            st_memory: begin
                if (!ctrl_q.is_load) pc_next = pc_seq;
            end
            st_writeback: pc_next = res_q.taken ? res_q.target : pc_seq;
            default:      pc_next = pc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= st_fetch;
            pc     <= reset_pc;
            ctrl_q <= '0;
        end else begin
            state <= state_next;
            pc    <= pc_next;
            if (state == st_decode) begin
                ctrl_q <= dec_ctrl;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            rj_q  <= rf_rdata1;
            rkd_q <= rf_rdata2;
        end
        if (state == st_execute) begin
            res_q <= exec_res;
        end
    end

    ////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////

    instr_decode u_instr_decode (
        .inst (inst_sram_rdata),
        .ctrl (dec_ctrl),
        .rj   (dec_rj),
        .rkd  (dec_rkd)
    );

    register_file u_register_file (
        .clk    (clk),
        .raddr1 (dec_rj),
        .raddr2 (dec_rkd),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    execute_unit u_execute_unit (
        .ctrl      (ctrl_q),
        .pc        (pc),
        .rj_value  (rj_q),
        .rkd_value (rkd_q),
        .result    (exec_res)
    );

    result_stage u_result_stage (
        .ctrl      (ctrl_q),
        .result    (res_q),
        .load_data (data_sram_rdata),
        .writeback (state == st_writeback),
        .rf_we     (rf_we),
        .rf_waddr  (rf_waddr),
        .rf_wdata  (rf_wdata)
    );

    ////////////////////////////////////////////////////////////
    // sram ports and trace
    ////////////////////////////////////////////////////////////

    assign inst_sram_addr    = pc;

    assign data_sram_we      = (state == st_memory) && ctrl_q.is_store;
    assign data_sram_addr    = res_q.alu_result;
    assign data_sram_wdata   = rkd_q;

    // pc still holds the retiring instruction during writeback
    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial reset = 1'b1;

    task automatic assert_reset();
        @(posedge clk);
        #1 reset = 1'b1;
    endtask

    // reset stays high for 16 rising edges before it falls
    task automatic release_reset();
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
    endtask

endmodule

`default_nettype wire

// File: testbench/core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module core_assertions (
    input wire        clk,
    input wire        reset,
    input wire        data_sram_we,
    input wire [3:0]  debug_wb_rf_we,
    input wire [31:0] inst_sram_addr
);

    int failure_count = 0;

    // a store occupies a single memory cycle
    assert property (@(posedge clk) disable iff (reset) data_sram_we |=> !data_sram_we)
        else begin
            failure_count++;
            $error("data_sram_we high on two consecutive cycles");
        end

    assert property (@(posedge clk) disable iff (reset)
        (debug_wb_rf_we == 4'h0) || (debug_wb_rf_we == 4'hf))
        else begin
            failure_count++;
            $error("debug_wb_rf_we is neither all zeros nor all ones");
        end

    assert property (@(posedge clk) disable iff (reset) inst_sram_addr[1:0] == 2'b00)
        else begin
            failure_count++;
            $error("inst_sram_addr is not word aligned");
        end

    // the first edge of a reset still shows the state from before it
    assert property (@(posedge clk) (reset && $past(reset)) |->
        (!data_sram_we && debug_wb_rf_we == 4'h0))
        else begin
            failure_count++;
            $error("write strobe active during reset");
        end

endmodule

bind multicycle_core core_assertions u_core_assertions (
    .clk            (clk),
    .reset          (reset),
    .data_sram_we   (data_sram_we),
    .debug_wb_rf_we (debug_wb_rf_we),
    .inst_sram_addr (inst_sram_addr)
);

`default_nettype wire

// File: testbench/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb import la32_isa_pkg::*; ();

    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [1024];
    logic [31:0] model_mem [1024];
    logic [31:0] model_regs [32];
    logic [31:0] lfsr = 32'hd03ec50c;
    int          emit_idx;
    int          cyc;
    string       current_test;

    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_val [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    int          write_cycle [$];

    tb_clock u_tb_clock (.clk(clk), .reset(reset));

    multicycle_core u_multicycle_core (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    ////////////////////////////////////////////////////////////
    // memory models, one cycle read latency
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] fill_word(input int i);
        return ({i[9:0], 2'b00} ^ 32'ha5c3_0000) ^ (i << 22);
    endfunction

    initial begin
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        for (int i = 0; i < 1024; i++) begin
            dmem[i]      = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
    end

    always @(posedge clk) begin
        logic [31:0] offs;
        offs = (inst_sram_addr - reset_pc) >> 2;
        #1 inst_sram_rdata = (offs < 256) ? imem[offs] : 32'h0;
    end

    always @(posedge clk) begin
        logic [9:0] idx;
        idx = data_sram_addr[11:2];
        if (data_sram_we) dmem[idx] = data_sram_wdata;
        #1 data_sram_rdata = dmem[idx];
    end

    ////////////////////////////////////////////////////////////
    // checking
    ////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH %s in %s: got %h, expected %h", name, current_test, got, expected);
            stop_with_failure();
        end
    endtask

    function automatic int assertion_failures();
        return u_multicycle_core.u_core_assertions.failure_count;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            cyc = 0;
        end else begin
            cyc++;
            if (debug_wb_rf_we != 4'h0) begin
                if (exp_pc.size() == 0) begin
                    $display("%s: unexpected register write at pc %h", current_test, debug_wb_pc);
                    stop_with_failure();
                end else begin
                    check("debug_wb_rf_we", debug_wb_rf_we, 32'hf);
                    check("debug_wb_pc", debug_wb_pc, exp_pc.pop_front());
                    check("debug_wb_rf_wnum", debug_wb_rf_wnum, exp_num.pop_front());
                    check("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_val.pop_front());
                    write_cycle.push_back(cyc);
                end
            end
            if (data_sram_we) begin
                if (exp_st_addr.size() == 0) begin
                    $display("%s: unexpected store to %h", current_test, data_sram_addr);
                    stop_with_failure();
                end else begin
                    check("data_sram_addr", data_sram_addr, exp_st_addr.pop_front());
                    check("data_sram_wdata", data_sram_wdata, exp_st_data.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        if (assertion_failures() != 0) begin
            $display("%s: a protocol assertion on the core failed", current_test);
            stop_with_failure();
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus and reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] encode(input opcode_t op, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [31:0] v);
        logic [4:0] k;
        k = v[4:0];
        case (op)
            op_add_w:   return {6'h00, 4'h0, 2'h1, 5'h00, k, rj, rd};
            op_sub_w:   return {6'h00, 4'h0, 2'h1, 5'h02, k, rj, rd};
            op_slt:     return {6'h00, 4'h0, 2'h1, 5'h04, k, rj, rd};
            op_sltu:    return {6'h00, 4'h0, 2'h1, 5'h05, k, rj, rd};
            op_nor:     return {6'h00, 4'h0, 2'h1, 5'h08, k, rj, rd};
            op_and:     return {6'h00, 4'h0, 2'h1, 5'h09, k, rj, rd};
            op_or:      return {6'h00, 4'h0, 2'h1, 5'h0a, k, rj, rd};
            op_xor:     return {6'h00, 4'h0, 2'h1, 5'h0b, k, rj, rd};
            op_slli_w:  return {6'h00, 4'h1, 2'h0, 5'h01, k, rj, rd};
            op_srli_w:  return {6'h00, 4'h1, 2'h0, 5'h09, k, rj, rd};
            op_srai_w:  return {6'h00, 4'h1, 2'h0, 5'h11, k, rj, rd};
            op_addi_w:  return {6'h00, 4'ha, v[11:0], rj, rd};
            op_lu12i_w: return {6'h05, 1'b0, v[31:12], rd};
            op_ld_w:    return {6'h0a, 4'h2, v[11:0], rj, rd};
            op_st_w:    return {6'h0a, 4'h6, v[11:0], rj, rd};
            op_jirl:    return {6'h13, v[17:2], rj, rd};
            op_b:       return {6'h14, v[17:2], v[27:18]};
            op_bl:      return {6'h15, v[17:2], v[27:18]};
            op_beq:     return {6'h16, v[17:2], rj, rd};
            op_bne:     return {6'h17, v[17:2], rj, rd};
            default:    return 32'h0;
        endcase
    endfunction

    // signed compare by sign bits, arithmetic shift by inverting around a logical one
    function automatic logic [31:0] model_alu(input opcode_t op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            op_add_w, op_addi_w: return a + b;
            op_sub_w:  return a - b;
            op_slt:    return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            op_sltu:   return {31'b0, a < b};
            op_nor:    return ~(a | b);
            op_and:    return a & b;
            op_or:     return a | b;
            op_xor:    return a ^ b;
            op_slli_w: return a << b[4:0];
            op_srli_w: return a >> b[4:0];
            op_srai_w: return a[31] ? ~(~a >> b[4:0]) : (a >> b[4:0]);
            default:   return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] cur_pc();
        return reset_pc + emit_idx * 4;
    endfunction

    task automatic put(input logic [31:0] word);
        imem[emit_idx] = word;
        emit_idx++;
    endtask

    // r0 shows up in the trace but keeps reading as zero
    task automatic expect_write(input logic [4:0] rd, input logic [31:0] val);
        exp_pc.push_back(cur_pc());
        exp_num.push_back(rd);
        exp_val.push_back(val);
        if (rd != 5'd0) model_regs[rd] = val;
    endtask

    task automatic rrr(input opcode_t op, input int rd, input int rj, input int rk);
        expect_write(rd, model_alu(op, model_regs[rj], model_regs[rk]));
        put(encode(op, rd, rj, rk));
    endtask

    task automatic ri(input opcode_t op, input int rd, input int rj, input logic [31:0] imm);
        expect_write(rd, model_alu(op, model_regs[rj], imm));
        put(encode(op, rd, rj, imm));
    endtask

    task automatic load_const(input int rd, input logic [31:0] val);
        logic [19:0] hi;
        hi = val[31:12] + val[11];
        expect_write(rd, {hi, 12'b0});
        put(encode(op_lu12i_w, rd, 0, {hi, 12'b0}));
        ri(op_addi_w, rd, rd, {{20{val[11]}}, val[11:0]});
    endtask

    task automatic store(input int rd, input int rj, input logic [31:0] imm);
        logic [31:0] addr;
        addr = model_regs[rj] + imm;
        exp_st_addr.push_back(addr);
        exp_st_data.push_back(model_regs[rd]);
        model_mem[addr[11:2]] = model_regs[rd];
        put(encode(op_st_w, rd, rj, imm));
    endtask

    task automatic load(input int rd, input int rj, input logic [31:0] imm);
        logic [31:0] addr;
        addr = model_regs[rj] + imm;
        expect_write(rd, model_mem[addr[11:2]]);
        put(encode(op_ld_w, rd, rj, imm));
    endtask

    // a slot that is jumped over would trace a write if it ran
    task automatic skip_slot();
        put(encode(op_addi_w, 20, 0, 32'h7ff));
    endtask

    task automatic cond_branch(input opcode_t op, input int rj, input int rd);
        logic eq;
        eq = (model_regs[rj] == model_regs[rd]);
        put(encode(op, rd, rj, 32'd8));
        if ((op == op_beq) == eq) skip_slot();
        else ri(op_addi_w, 20, 0, 32'h123);
    endtask

    task automatic jirl(input int rd, input int rj, input logic [31:0] offs);
        logic [31:0] target;
        target = model_regs[rj] + offs;
        expect_write(rd, cur_pc() + 4);
        put(encode(op_jirl, rd, rj, offs));
        while (cur_pc() != target && emit_idx < 250) skip_slot();
    endtask

    ////////////////////////////////////////////////////////////
    // test flow
    ////////////////////////////////////////////////////////////

    task automatic begin_test(input string name);
        current_test = name;
        u_tb_clock.assert_reset();
        for (int i = 0; i < 256; i++) imem[i] = 32'h0;
        emit_idx = 0;
        exp_pc.delete();
        exp_num.delete();
        exp_val.delete();
        exp_st_addr.delete();
        exp_st_data.delete();
        write_cycle.delete();
    endtask

    task automatic run_test();
        int limit;
        int waited;
        put(encode(op_b, 0, 0, 32'd0));
        limit  = 5 * emit_idx + 16 + 50;
        waited = 16;
        u_tb_clock.release_reset();
        while (exp_pc.size() > 0 || exp_st_addr.size() > 0) begin
            @(posedge clk);
            waited++;
            if (waited > limit) begin
                $display("%s: timeout, the core stopped retiring", current_test);
                stop_with_failure();
            end
        end
        // any late write lands on an empty queue and is caught
        repeat (10) @(posedge clk);
    endtask

    task automatic alu_reg_test();
        begin_test("alu_reg_test");
        load_const(11, rand_bits(32) | 32'h8000_0000);
        load_const(12, rand_bits(32) & 32'h7fff_ffff);
        rrr(op_add_w, 13, 11, 12);
        rrr(op_sub_w, 14, 11, 12);
        rrr(op_slt, 15, 11, 12);
        rrr(op_sltu, 16, 11, 12);
        rrr(op_nor, 17, 11, 12);
        rrr(op_and, 18, 11, 12);
        rrr(op_or, 19, 11, 12);
        rrr(op_xor, 21, 11, 12);
        rrr(op_slt, 22, 12, 11);
        rrr(op_sltu, 23, 12, 11);
        run_test();
    endtask

    task automatic shift_test();
        begin_test("shift_test");
        load_const(11, rand_bits(32) | 32'h8000_0000);
        ri(op_slli_w, 12, 11, rand_bits(5));
        ri(op_srli_w, 13, 11, rand_bits(5));
        ri(op_srai_w, 14, 11, rand_bits(5));
        ri(op_addi_w, 0, 11, 32'd5);
        rrr(op_add_w, 15, 0, 11);
        run_test();
    endtask

    task automatic load_store_test();
        begin_test("load_store_test");
        load_const(10, 32'h0000_1000);
        load_const(11, rand_bits(32));
        load_const(12, rand_bits(32));
        store(11, 10, 32'd8);
        store(12, 10, 32'hffff_fffc);
        load(13, 10, 32'd8);
        load(14, 10, 32'hffff_fffc);
        load(15, 10, 32'h20);
        run_test();
    endtask

    task automatic branch_test();
        logic [31:0] v;
        begin_test("branch_test");
        v = rand_bits(32);
        load_const(11, v);
        load_const(12, v);
        load_const(13, ~v);
        cond_branch(op_beq, 11, 12);
        cond_branch(op_beq, 11, 13);
        cond_branch(op_bne, 11, 13);
        cond_branch(op_bne, 11, 12);
        run_test();
    endtask

    task automatic jump_test();
        begin_test("jump_test");
        put(encode(op_b, 0, 0, 32'd8));
        skip_slot();
        expect_write(link_reg, cur_pc() + 4);
        put(encode(op_bl, 0, 0, 32'd8));
        skip_slot();
        jirl(2, 1, 32'd12);
        ri(op_addi_w, 24, 1, 32'd0);
        run_test();
    endtask

    task automatic timing_test();
        begin_test("timing_test");
        ri(op_addi_w, 5, 0, 32'h10);
        ri(op_addi_w, 6, 5, 32'h1);
        load(7, 0, 32'h40);
        run_test();
        check("alu write cycle", write_cycle[0], 32'd4);
        check("alu to alu cycles", write_cycle[1] - write_cycle[0], 32'd4);
        check("alu to load cycles", write_cycle[2] - write_cycle[1], 32'd5);
    endtask

    initial begin
        current_test = "none";
        alu_reg_test();
        shift_test();
        load_store_test();
        branch_test();
        jump_test();
        timing_test();
        if (assertion_failures() == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("%s: a protocol assertion on the core failed", current_test);
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

// File: la32_multicycle.f
logic/la32_isa_pkg.sv
logic/core_pkg.sv
logic/instr_decode.sv
logic/register_file.sv
logic/execute_unit.sv
logic/result_stage.sv
logic/multicycle_core.sv
testbench/tb_clock.sv
testbench/core_assertions.sv
testbench/core_tb.sv
